// ==== include/bev_macros.svh ====
`ifndef BEV_MACROS_SVH
`define BEV_MACROS_SVH

// Ingredient amount in a box record
`define BEV_ING_W   12
`define BEV_ING_MAX 12'd4095

// Cup volume per size
`define BEV_CUP_S   12'd480
`define BEV_CUP_M   12'd720
`define BEV_CUP_L   12'd960

// Memory bridge
`define BEV_BOX_W   8
`define BEV_REC_W   64

`endif

// ==== hdl/bev_pkg.sv ====
`include "bev_macros.svh"

package bev_pkg;

    typedef enum logic [1:0] {
        make_drink       = 2'd0,
        supply           = 2'd1,
        check_valid_date = 2'd2
    } action_t;

    typedef enum logic [2:0] {
        black_tea                = 3'd0,
        milk_tea                 = 3'd1,
        extra_milk_tea           = 3'd2,
        green_tea                = 3'd3,
        green_milk_tea           = 3'd4,
        pineapple_juice          = 3'd5,
        super_pineapple_tea      = 3'd6,
        super_pineapple_milk_tea = 3'd7
    } bev_type_t;

    typedef enum logic [1:0] {
        size_s = 2'd0,
        size_m = 2'd1,
        size_l = 2'd2
    } bev_size_t;

    typedef enum logic [1:0] {
        no_err = 2'd0,
        no_exp = 2'd1,
        no_ing = 2'd2,
        ing_of = 2'd3
    } err_msg_t;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    // Layout of one box in memory
    typedef struct packed {
        logic [`BEV_ING_W-1:0] black_tea;
        logic [`BEV_ING_W-1:0] green_tea;
        logic [7:0]            month;
        logic [`BEV_ING_W-1:0] milk;
        logic [`BEV_ING_W-1:0] pineapple_juice;
        logic [7:0]            day;
    } box_rec_t;

    typedef struct packed {
        logic                  sel_action_valid;
        logic                  type_valid;
        logic                  size_valid;
        logic                  date_valid;
        logic                  box_no_valid;
        logic                  box_sup_valid;
        logic [`BEV_ING_W-1:0] data;
    } order_in_t;

    // Supply lanes 0 to 3 hold black tea, green tea, milk and pineapple juice
    typedef struct packed {
        action_t                    act;
        bev_type_t                  bev_type;
        bev_size_t                  size;
        date_t                      date;
        logic [3:0][`BEV_ING_W-1:0] sup_amt;
    } order_ctx_t;

    typedef struct packed {
        logic     out_valid;
        logic     complete;
        err_msg_t err_msg;
    } result_t;

    typedef struct packed {
        logic                  in_valid;
        logic                  r_wb;
        logic [`BEV_BOX_W-1:0] addr;
        box_rec_t              data_w;
    } bridge_req_t;

    typedef struct packed {
        logic     out_valid;
        box_rec_t data_r;
    } bridge_rsp_t;

endpackage

// ==== hdl/bev_order_fsm.sv ====
`include "bev_macros.svh"

module bev_order_fsm
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  bev_pkg::order_in_t    order,
    input  logic                  rd_done,
    input  logic                  wb_busy,
    input  logic                  wb_needed,
    output bev_pkg::order_ctx_t   ctx,
    output logic [`BEV_BOX_W-1:0] box_no,
    output logic                  rd_start,
    output logic                  eval,
    output logic                  wb_start
);

    typedef enum logic [3:0] {
        idle,
        get_type,
        get_size,
        get_date,
        get_box,
        get_supply,
        wait_wb,
        read,
        evaluate,
        write_back
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic [1:0] sup_cnt;

    always_comb
    begin
        state_nxt = state;
        case (state)
            idle:
            begin
                if (order.sel_action_valid)
                begin
                    if (order.data[1:0] == bev_pkg::make_drink)
                        state_nxt = get_type;
                    else if (order.data[1:0] == bev_pkg::supply ||
                             order.data[1:0] == bev_pkg::check_valid_date)
                        state_nxt = get_date;
                end
            end
            get_type:
                if (order.type_valid) state_nxt = get_size;
            get_size:
                if (order.size_valid) state_nxt = get_date;
            get_date:
                if (order.date_valid) state_nxt = get_box;
            get_box:
            begin
                if (order.box_no_valid)
                    state_nxt = (ctx.act == bev_pkg::supply) ? get_supply : wait_wb;
            end
            get_supply:
                if (order.box_sup_valid && sup_cnt == 2'd3) state_nxt = wait_wb;
            // Previous order's write must land before this read
            wait_wb:
                if (!wb_busy) state_nxt = read;
            read:
                if (rd_done) state_nxt = evaluate;
            evaluate:
                state_nxt = wb_needed ? write_back : idle;
            default:
                state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= idle;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sup_cnt <= 2'd0;
        else if (state == idle)
            sup_cnt <= 2'd0;
        else if (state == get_supply && order.box_sup_valid)
            sup_cnt <= sup_cnt + 2'd1;
    end

    always_ff @(posedge clk)
    begin
        case (state)
            idle:
                if (order.sel_action_valid) ctx.act <= bev_pkg::action_t'(order.data[1:0]);
            get_type:
                if (order.type_valid) ctx.bev_type <= bev_pkg::bev_type_t'(order.data[2:0]);
            get_size:
                if (order.size_valid) ctx.size <= bev_pkg::bev_size_t'(order.data[1:0]);
            get_date:
                if (order.date_valid) ctx.date <= bev_pkg::date_t'(order.data[8:0]);
            get_box:
                if (order.box_no_valid) box_no <= order.data[`BEV_BOX_W-1:0];
            get_supply:
                if (order.box_sup_valid) ctx.sup_amt[sup_cnt] <= order.data;
            default: ;
        endcase
    end

    assign rd_start = (state == wait_wb) && !wb_busy;
    assign eval     = (state == evaluate);
    assign wb_start = (state == write_back);

endmodule

// ==== hdl/bev_inventory_calc.sv ====
`include "bev_macros.svh"

module bev_inventory_calc
(
    input  logic                clk,
    input  logic                rst_n,
    input  bev_pkg::order_ctx_t ctx,
    input  logic                rd_done,
    input  bev_pkg::box_rec_t   rd_data,
    input  logic                eval,
    output bev_pkg::result_t    result,
    output bev_pkg::box_rec_t   rec_next,
    output logic                wb_needed
);

    bev_pkg::box_rec_t          rec_q;
    bev_pkg::box_rec_t          rec_upd;
    bev_pkg::err_msg_t          err_d;
    logic [`BEV_ING_W-1:0]      cup;
    logic [3:0][`BEV_ING_W-1:0] cur_amt;
    logic [3:0][`BEV_ING_W-1:0] need_amt;
    logic [3:0][`BEV_ING_W:0]   diff;
    logic [3:0][`BEV_ING_W:0]   sum;
    logic [3:0]                 lack;
    logic [3:0]                 ovf;
    logic                       expired;

    assign cur_amt = {rec_q.pineapple_juice, rec_q.milk, rec_q.green_tea, rec_q.black_tea};

    // Box still good on the order date itself
    assign expired = {rec_q.month, rec_q.day} < {4'd0, ctx.date.month, 3'd0, ctx.date.day};

    always_comb
    begin
        case (ctx.size)
            bev_pkg::size_s: cup = `BEV_CUP_S;
            bev_pkg::size_m: cup = `BEV_CUP_M;
            default:         cup = `BEV_CUP_L;
        endcase
    end

    // Recipe split of the cup
    always_comb
    begin
        need_amt = '0;
        case (ctx.bev_type)
            bev_pkg::black_tea:
                need_amt[0] = cup;
            bev_pkg::milk_tea:
            begin
                need_amt[0] = cup - (cup >> 2);
                need_amt[2] = cup >> 2;
            end
            bev_pkg::extra_milk_tea:
            begin
                need_amt[0] = cup >> 1;
                need_amt[2] = cup >> 1;
            end
            bev_pkg::green_tea:
                need_amt[1] = cup;
            bev_pkg::green_milk_tea:
            begin
                need_amt[1] = cup >> 1;
                need_amt[2] = cup >> 1;
            end
            bev_pkg::pineapple_juice:
                need_amt[3] = cup;
            bev_pkg::super_pineapple_tea:
            begin
                need_amt[0] = cup >> 1;
                need_amt[3] = cup >> 1;
            end
            default:
            begin
                need_amt[0] = cup >> 1;
                need_amt[2] = cup >> 2;
                need_amt[3] = cup >> 2;
            end
        endcase
    end

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            diff[i] = {1'b0, cur_amt[i]} - {1'b0, need_amt[i]};
            sum[i]  = {1'b0, cur_amt[i]} + {1'b0, ctx.sup_amt[i]};
            lack[i] = diff[i][`BEV_ING_W];
            ovf[i]  = sum[i] > {1'b0, `BEV_ING_MAX};
        end
    end

    always_comb
    begin
        err_d   = bev_pkg::no_err;
        rec_upd = rec_q;
        case (ctx.act)
            bev_pkg::make_drink:
            begin
                // Expiry wins over a short ingredient
                if (expired)
                    err_d = bev_pkg::no_exp;
                else if (|lack)
                    err_d = bev_pkg::no_ing;
                rec_upd.black_tea       = diff[0][`BEV_ING_W-1:0];
                rec_upd.green_tea       = diff[1][`BEV_ING_W-1:0];
                rec_upd.milk            = diff[2][`BEV_ING_W-1:0];
                rec_upd.pineapple_juice = diff[3][`BEV_ING_W-1:0];
            end
            bev_pkg::supply:
            begin
                if (|ovf)
                    err_d = bev_pkg::ing_of;
                rec_upd.black_tea       = ovf[0] ? `BEV_ING_MAX : sum[0][`BEV_ING_W-1:0];
                rec_upd.green_tea       = ovf[1] ? `BEV_ING_MAX : sum[1][`BEV_ING_W-1:0];
                rec_upd.milk            = ovf[2] ? `BEV_ING_MAX : sum[2][`BEV_ING_W-1:0];
                rec_upd.pineapple_juice = ovf[3] ? `BEV_ING_MAX : sum[3][`BEV_ING_W-1:0];
                rec_upd.month           = {4'd0, ctx.date.month};
                rec_upd.day             = {3'd0, ctx.date.day};
            end
            bev_pkg::check_valid_date:
                if (expired) err_d = bev_pkg::no_exp;
            default: ;
        endcase
    end

    // Overflowed supply is still written with the clamped amounts
    assign wb_needed = (ctx.act == bev_pkg::make_drink && err_d == bev_pkg::no_err) ||
                       ctx.act == bev_pkg::supply;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result <= '0;
        end
        else
        begin
            result.out_valid <= eval;
            if (eval)
            begin
                result.complete <= (err_d == bev_pkg::no_err);
                result.err_msg  <= err_d;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_done)
            rec_q <= rd_data;
        else if (eval && wb_needed)
            rec_q <= rec_upd;
    end

    assign rec_next = rec_q;

endmodule

// ==== hdl/bev_bridge_port.sv ====
`include "bev_macros.svh"

module bev_bridge_port
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`BEV_BOX_W-1:0] box_no,
    input  logic                  rd_start,
    input  logic                  wb_start,
    input  bev_pkg::box_rec_t     rec_next,
    output bev_pkg::bridge_req_t  bridge_req,
    input  bev_pkg::bridge_rsp_t  bridge_rsp,
    output logic                  rd_done,
    output logic                  wb_busy
);

    logic                  rd_pend;
    logic                  r_wb_q;
    logic [`BEV_BOX_W-1:0] addr_q;
    logic [`BEV_REC_W-1:0] data_q;

    // Fields follow the start pulse, then hold until the answer
    always_comb
    begin
        bridge_req.in_valid = rd_start | wb_start;
        bridge_req.r_wb     = r_wb_q;
        bridge_req.addr     = addr_q;
        bridge_req.data_w   = bev_pkg::box_rec_t'(data_q);
        if (rd_start)
        begin
            bridge_req.r_wb = 1'b1;
            bridge_req.addr = box_no;
        end
        else if (wb_start)
        begin
            bridge_req.r_wb   = 1'b0;
            bridge_req.addr   = box_no;
            bridge_req.data_w = rec_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            r_wb_q  <= 1'b0;
            addr_q  <= '0;
            rd_pend <= 1'b0;
            wb_busy <= 1'b0;
        end
        else
        begin
            if (bridge_req.in_valid)
            begin
                r_wb_q <= bridge_req.r_wb;
                addr_q <= bridge_req.addr;
            end
            // One request in flight, so any answer closes it
            if (rd_start)
                rd_pend <= 1'b1;
            else if (bridge_rsp.out_valid)
                rd_pend <= 1'b0;
            if (wb_start)
                wb_busy <= 1'b1;
            else if (bridge_rsp.out_valid)
                wb_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wb_start)
            data_q <= rec_next;
    end

    assign rd_done = bridge_rsp.out_valid & rd_pend;

endmodule

// ==== hdl/bev_top.sv ====
`include "bev_macros.svh"

module bev_top
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  bev_pkg::order_in_t   order,
    output bev_pkg::result_t     result,
    output bev_pkg::bridge_req_t bridge_req,
    input  bev_pkg::bridge_rsp_t bridge_rsp
);

    bev_pkg::order_ctx_t   ctx;
    bev_pkg::box_rec_t     rec_next;
    logic [`BEV_BOX_W-1:0] box_no;
    logic                  rd_start;
    logic                  rd_done;
    logic                  eval;
    logic                  wb_start;
    logic                  wb_busy;
    logic                  wb_needed;

    bev_order_fsm order_fsm_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .order     (order),
        .rd_done   (rd_done),
        .wb_busy   (wb_busy),
        .wb_needed (wb_needed),
        .ctx       (ctx),
        .box_no    (box_no),
        .rd_start  (rd_start),
        .eval      (eval),
        .wb_start  (wb_start)
    );

    bev_inventory_calc inventory_calc_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctx       (ctx),
        .rd_done   (rd_done),
        .rd_data   (bridge_rsp.data_r),
        .eval      (eval),
        .result    (result),
        .rec_next  (rec_next),
        .wb_needed (wb_needed)
    );

    bev_bridge_port bridge_port_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .box_no     (box_no),
        .rd_start   (rd_start),
        .wb_start   (wb_start),
        .rec_next   (rec_next),
        .bridge_req (bridge_req),
        .bridge_rsp (bridge_rsp),
        .rd_done    (rd_done),
        .wb_busy    (wb_busy)
    );

endmodule

// ==== bench/bev_bridge_model.sv ====
module bev_bridge_model
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  bev_pkg::bridge_req_t req,
    output bev_pkg::bridge_rsp_t rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    bev_pkg::box_rec_t    mem [0:255];
    bev_pkg::bridge_req_t held;
    logic                 busy;
    int                   delay;
    integer               seed;

    initial
    begin
        seed = 32'hff6696bc;
        // Every byte carries the address
        for (int a = 0; a < 256; a++)
            mem[a] = {8{8'(a) ^ 8'h5a}};
    end

    task automatic preload(input logic [7:0] addr, input bev_pkg::box_rec_t rec);
        mem[addr] = rec;
    endtask

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy  <= 1'b0;
            delay <= 0;
            rsp   <= '0;
        end
        else
        begin
            rsp.out_valid <= 1'b0;
            if (req.in_valid)
            begin
                held  <= req;
                busy  <= 1'b1;
                delay <= 1 + int'($unsigned($random(seed)) % 6);
            end
            else if (busy && delay > 1)
                delay <= delay - 1;
            else if (busy)
            begin
                busy          <= 1'b0;
                rsp.out_valid <= 1'b1;
                if (held.r_wb)
                    rsp.data_r <= mem[held.addr];
                else
                    mem[held.addr] = held.data_w;
            end
        end
    end

endmodule

// ==== bench/bev_properties.sv ====
module bev_properties
(
    input logic                 clk,
    input logic                 rst_n,
    input bev_pkg::result_t     result,
    input bev_pkg::bridge_req_t bridge_req,
    input bev_pkg::bridge_rsp_t bridge_rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    logic req_open;
    int   fail_cnt = 0;

    // Request accepted by the memory but not yet answered
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            req_open <= 1'b0;
        else if (bridge_req.in_valid)
            req_open <= 1'b1;
        else if (bridge_rsp.out_valid)
            req_open <= 1'b0;
    end

    out_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result.out_valid |=> !result.out_valid)
    else
    begin
        $error("result.out_valid high for more than one cycle");
        fail_cnt++;
    end

    in_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        bridge_req.in_valid |=> !bridge_req.in_valid)
    else
    begin
        $error("bridge_req.in_valid high for more than one cycle");
        fail_cnt++;
    end

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        bridge_req.in_valid |-> !req_open)
    else
    begin
        $error("bridge request issued while another is outstanding");
        fail_cnt++;
    end

    complete_no_err: assert property (@(posedge clk) disable iff (!rst_n)
        (result.out_valid && result.complete) |-> result.err_msg == bev_pkg::no_err)
    else
    begin
        $error("result.complete set with an error code");
        fail_cnt++;
    end

endmodule

bind bev_top bev_properties properties_inst
(
    .clk        (clk),
    .rst_n      (rst_n),
    .result     (result),
    .bridge_req (bridge_req),
    .bridge_rsp (bridge_rsp)
);

// ==== bench/bev_tb.sv ====
`include "bev_macros.svh"

module bev_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // 32 orders of at most 60 cycles plus reset and margin
    localparam int order_count    = 32;
    localparam int order_cycles   = 60;
    localparam int timeout_cycles = order_count * order_cycles + 580;

    localparam logic [5:0] v_action = 6'b100000;
    localparam logic [5:0] v_type   = 6'b010000;
    localparam logic [5:0] v_size   = 6'b001000;
    localparam logic [5:0] v_date   = 6'b000100;
    localparam logic [5:0] v_box    = 6'b000010;
    localparam logic [5:0] v_sup    = 6'b000001;

    localparam logic [3:0][`BEV_ING_W-1:0] no_sup = '0;

    logic                 clk;
    logic                 rst_n;
    bev_pkg::order_in_t   order;
    bev_pkg::result_t     result;
    bev_pkg::bridge_req_t bridge_req;
    bev_pkg::bridge_rsp_t bridge_rsp;

    bev_pkg::box_rec_t     ref_mem [0:255];
    bev_pkg::result_t      last_res;
    bev_pkg::box_rec_t     wr_data;
    logic [`BEV_BOX_W-1:0] wr_addr;
    int                    wr_cnt = 0;
    int                    wr_mark = 0;
    int                    cycle_cnt = 0;
    int                    err_cnt = 0;
    int                    test_cnt = 0;
    int                    test_fail = 0;
    int                    test_err_mark = 0;
    int                    assert_fails;

    bev_top bev_top_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .order      (order),
        .result     (result),
        .bridge_req (bridge_req),
        .bridge_rsp (bridge_rsp)
    );

    bev_bridge_model bridge_model_inst
    (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (bridge_req),
        .rsp   (bridge_rsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles)
        begin
            $display("timeout: run still busy after %0d cycles", cycle_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Write requests seen on the bridge
    always @(negedge clk)
    begin
        if (rst_n && bridge_req.in_valid && !bridge_req.r_wb)
        begin
            wr_cnt  = wr_cnt + 1;
            wr_addr = bridge_req.addr;
            wr_data = bridge_req.data_w;
        end
    end

    function automatic int cup_ml(input bev_pkg::bev_size_t sz);
        if (sz == bev_pkg::size_s)
            return 480;
        if (sz == bev_pkg::size_m)
            return 720;
        return 960;
    endfunction

    // Quarters of the cup per ingredient in lanes {pineapple, milk, green, black}
    function automatic logic [3:0][`BEV_ING_W-1:0] recipe_need(input bev_pkg::bev_type_t bt,
                                                               input bev_pkg::bev_size_t sz);
        logic [3:0][2:0]            q;
        logic [3:0][`BEV_ING_W-1:0] need;
        case (bt)
            bev_pkg::black_tea:           q = {3'd0, 3'd0, 3'd0, 3'd4};
            bev_pkg::milk_tea:            q = {3'd0, 3'd1, 3'd0, 3'd3};
            bev_pkg::extra_milk_tea:      q = {3'd0, 3'd2, 3'd0, 3'd2};
            bev_pkg::green_tea:           q = {3'd0, 3'd0, 3'd4, 3'd0};
            bev_pkg::green_milk_tea:      q = {3'd0, 3'd2, 3'd2, 3'd0};
            bev_pkg::pineapple_juice:     q = {3'd4, 3'd0, 3'd0, 3'd0};
            bev_pkg::super_pineapple_tea: q = {3'd2, 3'd0, 3'd0, 3'd2};
            default:                      q = {3'd1, 3'd1, 3'd0, 3'd2};
        endcase
        for (int i = 0; i < 4; i++)
            need[i] = 12'(cup_ml(sz) * int'(q[i]) / 4);
        return need;
    endfunction

    function automatic bev_pkg::box_rec_t predict_rec(input bev_pkg::box_rec_t old,
            input bev_pkg::action_t act, input bev_pkg::bev_type_t bt,
            input bev_pkg::bev_size_t sz, input logic [3:0] mon, input logic [4:0] day,
            input logic [3:0][`BEV_ING_W-1:0] sup);
        logic [3:0][`BEV_ING_W-1:0] amt;
        logic [3:0][`BEV_ING_W-1:0] need;
        bev_pkg::box_rec_t          rec;
        int                         sum;
        amt  = {old.pineapple_juice, old.milk, old.green_tea, old.black_tea};
        need = recipe_need(bt, sz);
        rec  = old;
        for (int i = 0; i < 4; i++)
        begin
            if (act == bev_pkg::supply)
            begin
                sum    = int'(amt[i]) + int'(sup[i]);
                amt[i] = (sum > int'(`BEV_ING_MAX)) ? `BEV_ING_MAX : 12'(sum);
            end
            else if (act == bev_pkg::make_drink)
                amt[i] = amt[i] - need[i];
        end
        rec.black_tea       = amt[0];
        rec.green_tea       = amt[1];
        rec.milk            = amt[2];
        rec.pineapple_juice = amt[3];
        if (act == bev_pkg::supply)
        begin
            rec.month = {4'd0, mon};
            rec.day   = {3'd0, day};
        end
        return rec;
    endfunction

    function automatic bev_pkg::box_rec_t make_box(input int bt, gt, milk, pj, mon, day);
        bev_pkg::box_rec_t rec;
        rec.black_tea       = 12'(bt);
        rec.green_tea       = 12'(gt);
        rec.milk            = 12'(milk);
        rec.pineapple_juice = 12'(pj);
        rec.month           = 8'(mon);
        rec.day             = 8'(day);
        return rec;
    endfunction

    task automatic load_box(input logic [7:0] box, input bev_pkg::box_rec_t rec);
        ref_mem[box] = rec;
        bridge_model_inst.preload(box, rec);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        err_cnt++;
    endtask

    task automatic drive_field(input logic [5:0] valid, input logic [`BEV_ING_W-1:0] data);
        order = {valid, data};
        @(posedge clk);
        #5;
        order = '0;
    endtask

    task automatic place_order(input bev_pkg::action_t act, input bev_pkg::bev_type_t bt,
            input bev_pkg::bev_size_t sz, input logic [3:0] mon, input logic [4:0] day,
            input logic [7:0] box, input logic [3:0][`BEV_ING_W-1:0] sup);
        wr_mark = wr_cnt;
        drive_field(v_action, {10'd0, act});
        if (act == bev_pkg::make_drink)
        begin
            drive_field(v_type, {9'd0, bt});
            drive_field(v_size, {10'd0, sz});
        end
        drive_field(v_date, {3'd0, mon, day});
        drive_field(v_box, {4'd0, box});
        if (act == bev_pkg::supply)
            for (int i = 0; i < 4; i++)
                drive_field(v_sup, sup[i]);
        while (result.out_valid !== 1'b1)
            @(negedge clk);
        last_res = result;
        @(posedge clk);
        #5;
    endtask

    task automatic order_and_check(input bev_pkg::action_t act, input bev_pkg::bev_type_t bt,
            input bev_pkg::bev_size_t sz, input logic [3:0] mon, input logic [4:0] day,
            input logic [7:0] box, input logic [3:0][`BEV_ING_W-1:0] sup,
            input bev_pkg::err_msg_t exp_err);
        bev_pkg::box_rec_t exp_rec;
        logic              exp_wr;
        exp_rec = predict_rec(ref_mem[box], act, bt, sz, mon, day, sup);
        exp_wr  = (act == bev_pkg::supply) ||
                  (act == bev_pkg::make_drink && exp_err == bev_pkg::no_err);
        place_order(act, bt, sz, mon, day, box, sup);
        if (last_res.err_msg !== exp_err)
            report_mismatch("result.err_msg", 64'(last_res.err_msg), 64'(exp_err));
        if (last_res.complete !== (exp_err == bev_pkg::no_err))
            report_mismatch("result.complete", 64'(last_res.complete),
                            64'(exp_err == bev_pkg::no_err));
        if (exp_wr && wr_cnt != wr_mark + 1)
        begin
            $display("expected one write to box %0d but saw %0d", box, wr_cnt - wr_mark);
            err_cnt++;
        end
        else if (!exp_wr && wr_cnt != wr_mark)
        begin
            $display("box %0d was written although the order needs no write", box);
            err_cnt++;
        end
        else if (exp_wr)
        begin
            if (wr_addr !== box)
                report_mismatch("bridge_req.addr", 64'(wr_addr), 64'(box));
            if (wr_data !== exp_rec)
                report_mismatch("bridge_req.data_w", wr_data, exp_rec);
            ref_mem[box] = exp_rec;
        end
    endtask

    task automatic start_test();
        test_err_mark = err_cnt;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt == test_err_mark)
            $display("test %s: ok", name);
        else
        begin
            test_fail++;
            $display("test %s: %0d errors", name, err_cnt - test_err_mark);
        end
    endtask

    task automatic check_date_test();
        start_test();
        load_box(8'd3, make_box(1000, 1000, 1000, 1000, 12, 31));
        load_box(8'd4, make_box(1000, 1000, 1000, 1000, 3, 10));
        order_and_check(bev_pkg::check_valid_date, bev_pkg::black_tea, bev_pkg::size_s,
                        4'd6, 5'd15, 8'd3, no_sup, bev_pkg::no_err);
        order_and_check(bev_pkg::check_valid_date, bev_pkg::black_tea, bev_pkg::size_s,
                        4'd6, 5'd15, 8'd4, no_sup, bev_pkg::no_exp);
        finish_test("check valid date");
    endtask

    task automatic all_drinks_test();
        bev_pkg::bev_type_t bt;
        bev_pkg::bev_size_t sz;
        logic [7:0]         box;
        start_test();
        for (int t = 0; t < 8; t++)
            for (int s = 0; s < 3; s++)
                load_box(8'(32 + t * 3 + s), make_box(4095, 4000, 3000, 2000, 12, 31));
        for (int t = 0; t < 8; t++)
            for (int s = 0; s < 3; s++)
            begin
                bt  = bev_pkg::bev_type_t'(3'(t));
                sz  = bev_pkg::bev_size_t'(2'(s));
                box = 8'(32 + t * 3 + s);
                order_and_check(bev_pkg::make_drink, bt, sz, 4'd6, 5'd15, box, no_sup,
                                bev_pkg::no_err);
            end
        finish_test("all drinks and sizes");
    endtask

    task automatic short_ingredient_test();
        start_test();
        load_box(8'd80, make_box(100, 4000, 4000, 4000, 12, 31));
        order_and_check(bev_pkg::make_drink, bev_pkg::milk_tea, bev_pkg::size_l,
                        4'd6, 5'd15, 8'd80, no_sup, bev_pkg::no_ing);
        finish_test("short ingredient");
    endtask

    task automatic expiry_first_test();
        start_test();
        load_box(8'd81, make_box(100, 4000, 4000, 4000, 1, 5));
        order_and_check(bev_pkg::make_drink, bev_pkg::black_tea, bev_pkg::size_m,
                        4'd6, 5'd15, 8'd81, no_sup, bev_pkg::no_exp);
        finish_test("expiry before shortage");
    endtask

    task automatic supply_test();
        start_test();
        load_box(8'd90, make_box(1000, 2000, 3000, 100, 2, 1));
        load_box(8'd91, make_box(4000, 100, 4095, 0, 2, 1));
        order_and_check(bev_pkg::supply, bev_pkg::black_tea, bev_pkg::size_s, 4'd7, 5'd20,
                        8'd90, {12'd200, 12'd1000, 12'd1000, 12'd500}, bev_pkg::no_err);
        order_and_check(bev_pkg::supply, bev_pkg::black_tea, bev_pkg::size_s, 4'd7, 5'd20,
                        8'd91, {12'd0, 12'd1, 12'd100, 12'd200}, bev_pkg::ing_of);
        finish_test("supply and overflow");
    endtask

    task automatic supply_then_make_test();
        start_test();
        load_box(8'd100, make_box(0, 0, 0, 0, 1, 1));
        order_and_check(bev_pkg::supply, bev_pkg::black_tea, bev_pkg::size_s, 4'd8, 5'd1,
                        8'd100, {4{12'd960}}, bev_pkg::no_err);
        // Read must see the record written just before
        order_and_check(bev_pkg::make_drink, bev_pkg::black_tea, bev_pkg::size_l, 4'd8, 5'd1,
                        8'd100, no_sup, bev_pkg::no_err);
        finish_test("make after supply");
    endtask

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;
        order = '0;
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(posedge clk);
        #5;
        check_date_test();
        all_drinks_test();
        short_ingredient_test();
        expiry_first_test();
        supply_test();
        supply_then_make_test();
        assert_fails = bev_top_inst.properties_inst.fail_cnt;
        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 test_cnt, test_fail, err_cnt, assert_fails);
        if (test_fail == 0 && err_cnt == 0 && assert_fails == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/bev_pkg.sv
hdl/bev_order_fsm.sv
hdl/bev_inventory_calc.sv
hdl/bev_bridge_port.sv
hdl/bev_top.sv
bench/bev_bridge_model.sv
bench/bev_properties.sv
bench/bev_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = bev_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+100
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
